// ==== common/tlb_xlat_pkg.sv ====
`default_nettype none

// Address translation widths and types shared by the table and its channels
package tlb_xlat_pkg;

  // Input address space
  localparam int unsigned INP_ADDR_W = 32;
  // Output address space, wider than the input side
  localparam int unsigned OUP_ADDR_W = 34;

  // 4 KiB pages
  localparam int unsigned PAGE_OFS_W = 12;

  // Page number widths follow from the address widths
  localparam int unsigned INP_PAGE_W = INP_ADDR_W - PAGE_OFS_W;
  localparam int unsigned OUP_PAGE_W = OUP_ADDR_W - PAGE_OFS_W;

  // Number of flag bits per entry
  localparam int unsigned FLAGS_W = 3;

  // Flag bit positions
  localparam int unsigned FLAG_VALID = 0;
  localparam int unsigned FLAG_READ  = 1;
  localparam int unsigned FLAG_WRITE = 2;

  // Full addresses
  typedef logic [INP_ADDR_W-1:0] inp_addr_t;
  typedef logic [OUP_ADDR_W-1:0] oup_addr_t;

  // Page numbers, address without the page offset
  typedef logic [INP_PAGE_W-1:0] inp_page_t;
  typedef logic [OUP_PAGE_W-1:0] oup_page_t;

  // Valid, readable, writable
  typedef logic [FLAGS_W-1:0] flags_t;

endpackage

`default_nettype wire

// ==== common/tlb_cfg_pkg.sv ====
`default_nettype none

// Register map of the word-wide configuration port
package tlb_cfg_pkg;

  // Word address and data widths
  localparam int unsigned CFG_ADDR_W = 8;
  localparam int unsigned CFG_DATA_W = 32;

  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;

  // Each entry spans four consecutive words
  localparam int unsigned WORDS_PER_ENTRY = 4;

  // Address bits that select the field inside an entry
  localparam int unsigned OFS_W = $clog2(WORDS_PER_ENTRY);

  // Field word offsets inside one entry
  localparam int unsigned OFS_FIRST = 0;
  localparam int unsigned OFS_LAST  = 1;
  localparam int unsigned OFS_BASE  = 2;
  localparam int unsigned OFS_FLAGS = 3;

endpackage

`default_nettype wire

// ==== tlb_l1/tlb_l1_ft_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// One-deep fall-through register for a translation result
module tlb_l1_ft_reg (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  logic                    hit_i,
  input  tlb_xlat_pkg::oup_addr_t addr_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic                    hit_o,
  output tlb_xlat_pkg::oup_addr_t addr_o
);

  logic                    full_q;
  logic                    hit_q;
  tlb_xlat_pkg::oup_addr_t addr_q;
  logic                    capture;

  // Result offered but not taken while empty
  assign capture = valid_i && !ready_i && !full_q;

  // Only accept new input when nothing is held
  assign ready_o = !full_q;

  // Held result first, otherwise straight through
  assign valid_o = full_q || valid_i;
  assign hit_o   = full_q ? hit_q : hit_i;
  assign addr_o  = full_q ? addr_q : addr_i;

  // Occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Empties on the downstream handshake
      if (ready_i) begin
        full_q <= 1'b0;
      end
    end else if (capture) begin
      full_q <= 1'b1;
    end
  end

  // Stored result
  always_ff @(posedge clk_i) begin
    if (capture) begin
      hit_q  <= hit_i;
      addr_q <= addr_i;
    end
  end

  // Output stays put under back-pressure, across capture and hold
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(hit_o) && $stable(addr_o))
  ) else $error("Result changed while waiting for ready_i");

endmodule

`default_nettype wire

// ==== tlb_l1/tlb_l1_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Entry register file behind the configuration port
module tlb_l1_regs #(
  parameter int unsigned NumEntries = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     cfg_we_i,
  input  tlb_cfg_pkg::cfg_addr_t                   cfg_addr_i,
  input  tlb_cfg_pkg::cfg_data_t                   cfg_wdata_i,
  output tlb_cfg_pkg::cfg_data_t                   cfg_rdata_o,
  output tlb_xlat_pkg::inp_page_t [NumEntries-1:0] ent_first_o,
  output tlb_xlat_pkg::inp_page_t [NumEntries-1:0] ent_last_o,
  output tlb_xlat_pkg::oup_page_t [NumEntries-1:0] ent_base_o,
  output tlb_xlat_pkg::flags_t    [NumEntries-1:0] ent_flags_o
);

  // Upper address bits pick the entry
  localparam int unsigned IdxW = tlb_cfg_pkg::CFG_ADDR_W - tlb_cfg_pkg::OFS_W;

  logic [IdxW-1:0]               ent_idx;
  logic [tlb_cfg_pkg::OFS_W-1:0] fld_sel;
  logic                          ent_hit;

  // Stored fields, only the meaningful bits
  tlb_xlat_pkg::inp_page_t [NumEntries-1:0] first_q;
  tlb_xlat_pkg::inp_page_t [NumEntries-1:0] last_q;
  tlb_xlat_pkg::oup_page_t [NumEntries-1:0] base_q;
  tlb_xlat_pkg::flags_t    [NumEntries-1:0] flags_q;

  // Word address is entry index times words per entry plus field offset
  assign ent_idx = cfg_addr_i[tlb_cfg_pkg::CFG_ADDR_W-1:tlb_cfg_pkg::OFS_W];
  assign fld_sel = cfg_addr_i[tlb_cfg_pkg::OFS_W-1:0];

  // Words past the last entry are unmapped
  assign ent_hit = 32'(ent_idx) < NumEntries;

  // Field writes, upper data bits dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // All entries cleared, so nothing is valid
      first_q <= '0;
      last_q  <= '0;
      base_q  <= '0;
      flags_q <= '0;
    end else if (cfg_we_i && ent_hit) begin
      case (fld_sel)
        tlb_cfg_pkg::OFS_FIRST: begin
          first_q[ent_idx] <= cfg_wdata_i[tlb_xlat_pkg::INP_PAGE_W-1:0];
        end
        tlb_cfg_pkg::OFS_LAST: begin
          last_q[ent_idx] <= cfg_wdata_i[tlb_xlat_pkg::INP_PAGE_W-1:0];
        end
        tlb_cfg_pkg::OFS_BASE: begin
          base_q[ent_idx] <= cfg_wdata_i[tlb_xlat_pkg::OUP_PAGE_W-1:0];
        end
        tlb_cfg_pkg::OFS_FLAGS: begin
          flags_q[ent_idx] <= cfg_wdata_i[tlb_xlat_pkg::FLAGS_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Readback, zero-extended to a full word
  always_comb begin
    cfg_rdata_o = '0;
    if (ent_hit) begin
      case (fld_sel)
        tlb_cfg_pkg::OFS_FIRST: cfg_rdata_o = tlb_cfg_pkg::cfg_data_t'(first_q[ent_idx]);
        tlb_cfg_pkg::OFS_LAST:  cfg_rdata_o = tlb_cfg_pkg::cfg_data_t'(last_q[ent_idx]);
        tlb_cfg_pkg::OFS_BASE:  cfg_rdata_o = tlb_cfg_pkg::cfg_data_t'(base_q[ent_idx]);
        tlb_cfg_pkg::OFS_FLAGS: cfg_rdata_o = tlb_cfg_pkg::cfg_data_t'(flags_q[ent_idx]);
        default:                cfg_rdata_o = '0;
      endcase
    end
  end

  // Table seen by both channels
  assign ent_first_o = first_q;
  assign ent_last_o  = last_q;
  assign ent_base_o  = base_q;
  assign ent_flags_o = flags_q;

  // A write with an unknown address would corrupt an arbitrary entry
  a_cfg_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_we_i |-> !$isunknown(cfg_addr_i)
  ) else $error("cfg_addr_i unknown during a configuration write");

endmodule

`default_nettype wire

// ==== tlb_l1/tlb_l1_chan.sv ====
`timescale 1ns/1ps
`default_nettype none

// One lookup channel of the translation table
module tlb_l1_chan #(
  parameter int unsigned NumEntries = 4,
  // Selects the writable flag instead of the readable one
  parameter bit          IsWrite    = 1'b0
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  tlb_xlat_pkg::inp_page_t [NumEntries-1:0] ent_first_i,
  input  tlb_xlat_pkg::inp_page_t [NumEntries-1:0] ent_last_i,
  input  tlb_xlat_pkg::oup_page_t [NumEntries-1:0] ent_base_i,
  input  tlb_xlat_pkg::flags_t    [NumEntries-1:0] ent_flags_i,
  input  tlb_xlat_pkg::inp_addr_t                  req_addr_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  output logic                                     res_hit_o,
  output tlb_xlat_pkg::oup_addr_t                  res_addr_o,
  output logic                                     res_valid_o,
  input  logic                                     res_ready_i
);

  // Permission bit this channel needs
  localparam int unsigned PermBit =
      IsWrite ? tlb_xlat_pkg::FLAG_WRITE : tlb_xlat_pkg::FLAG_READ;

  tlb_xlat_pkg::inp_page_t req_page;
  logic [NumEntries-1:0]   ent_match;

  // Winning entry
  logic                    lookup_hit;
  tlb_xlat_pkg::inp_page_t hit_first;
  tlb_xlat_pkg::oup_page_t hit_base;

  // Rebased address
  tlb_xlat_pkg::inp_page_t page_delta;
  tlb_xlat_pkg::oup_page_t xlat_page;
  tlb_xlat_pkg::oup_addr_t xlat_addr;

  // Strip the page offset
  assign req_page = req_addr_i[tlb_xlat_pkg::INP_ADDR_W-1:tlb_xlat_pkg::PAGE_OFS_W];

  // Per entry: valid, permitted and page inside [first, last]
  for (genvar i = 0; i < NumEntries; i++) begin : gen_match
    assign ent_match[i] = ent_flags_i[i][tlb_xlat_pkg::FLAG_VALID]
        & ent_flags_i[i][PermBit]
        & (req_page >= ent_first_i[i])
        & (req_page <= ent_last_i[i]);
  end

  // Priority scan, downward so the lowest matching index is assigned last
  always_comb begin
    lookup_hit = 1'b0;
    hit_first  = '0;
    hit_base   = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (ent_match[i]) begin
        lookup_hit = 1'b1;
        hit_first  = ent_first_i[i];
        hit_base   = ent_base_i[i];
      end
    end
  end

  // Distance into the segment, never negative on a hit
  assign page_delta = req_page - hit_first;

  // Same distance from the output base page
  assign xlat_page = tlb_xlat_pkg::oup_page_t'(page_delta) + hit_base;

  // Offset passes through; a miss gives address zero
  assign xlat_addr = lookup_hit ?
      {xlat_page, req_addr_i[tlb_xlat_pkg::PAGE_OFS_W-1:0]} : '0;

  // Hold the result so later table writes cannot change it
  tlb_l1_ft_reg i_res_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .hit_i   (lookup_hit),
    .addr_i  (xlat_addr),
    .valid_o (res_valid_o),
    .ready_i (res_ready_i),
    .hit_o   (res_hit_o),
    .addr_o  (res_addr_o)
  );

endmodule

`default_nettype wire

// ==== src/tlb_l1_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// First-level translation table with a write and a read lookup channel
module tlb_l1_top #(
  parameter int unsigned NumEntries = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Configuration port
  input  logic                    cfg_we_i,
  input  tlb_cfg_pkg::cfg_addr_t  cfg_addr_i,
  input  tlb_cfg_pkg::cfg_data_t  cfg_wdata_i,
  output tlb_cfg_pkg::cfg_data_t  cfg_rdata_o,
  // Write channel
  input  tlb_xlat_pkg::inp_addr_t wr_req_addr_i,
  input  logic                    wr_req_valid_i,
  output logic                    wr_req_ready_o,
  output logic                    wr_res_hit_o,
  output tlb_xlat_pkg::oup_addr_t wr_res_addr_o,
  output logic                    wr_res_valid_o,
  input  logic                    wr_res_ready_i,
  // Read channel
  input  tlb_xlat_pkg::inp_addr_t rd_req_addr_i,
  input  logic                    rd_req_valid_i,
  output logic                    rd_req_ready_o,
  output logic                    rd_res_hit_o,
  output tlb_xlat_pkg::oup_addr_t rd_res_addr_o,
  output logic                    rd_res_valid_o,
  input  logic                    rd_res_ready_i
);

  // Table shared by both channels
  tlb_xlat_pkg::inp_page_t [NumEntries-1:0] ent_first;
  tlb_xlat_pkg::inp_page_t [NumEntries-1:0] ent_last;
  tlb_xlat_pkg::oup_page_t [NumEntries-1:0] ent_base;
  tlb_xlat_pkg::flags_t    [NumEntries-1:0] ent_flags;

  tlb_l1_regs #(
    .NumEntries (NumEntries)
  ) i_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .ent_first_o (ent_first),
    .ent_last_o  (ent_last),
    .ent_base_o  (ent_base),
    .ent_flags_o (ent_flags)
  );

  // Write lookups need the writable flag
  tlb_l1_chan #(
    .NumEntries (NumEntries),
    .IsWrite    (1'b1)
  ) i_wr_chan (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ent_first_i (ent_first),
    .ent_last_i  (ent_last),
    .ent_base_i  (ent_base),
    .ent_flags_i (ent_flags),
    .req_addr_i  (wr_req_addr_i),
    .req_valid_i (wr_req_valid_i),
    .req_ready_o (wr_req_ready_o),
    .res_hit_o   (wr_res_hit_o),
    .res_addr_o  (wr_res_addr_o),
    .res_valid_o (wr_res_valid_o),
    .res_ready_i (wr_res_ready_i)
  );

  // Read lookups need the readable flag
  tlb_l1_chan #(
    .NumEntries (NumEntries),
    .IsWrite    (1'b0)
  ) i_rd_chan (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ent_first_i (ent_first),
    .ent_last_i  (ent_last),
    .ent_base_i  (ent_base),
    .ent_flags_i (ent_flags),
    .req_addr_i  (rd_req_addr_i),
    .req_valid_i (rd_req_valid_i),
    .req_ready_o (rd_req_ready_o),
    .res_hit_o   (rd_res_hit_o),
    .res_addr_o  (rd_res_addr_o),
    .res_valid_o (rd_res_valid_o),
    .res_ready_i (rd_res_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and synchronous active-low reset for the testbench
module tb_clk_gen #(
  parameter int unsigned PeriodNs  = 20,
  parameter int unsigned RstCycles = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held over several rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_tlb_l1_vectors.svh ====
`ifndef TB_TLB_L1_VECTORS_SVH
`define TB_TLB_L1_VECTORS_SVH

// Columns: op, cfg word address, cfg data or expected readback,
// lookup address, expected hit, expected output address

// Row operations
localparam logic [2:0] OpCfgWr    = 3'd0;
localparam logic [2:0] OpCfgRd    = 3'd1;
localparam logic [2:0] OpLookupWr = 3'd2;
localparam logic [2:0] OpLookupRd = 3'd3;
// Read lookup held back while the cfg column is written
localparam logic [2:0] OpHoldRd   = 3'd4;

typedef struct packed {
  logic [2:0]  op;
  logic [7:0]  cfg_addr;
  logic [31:0] cfg_data;
  logic [31:0] req_addr;
  logic        exp_hit;
  logic [33:0] exp_addr;
} vec_t;

localparam int unsigned NumRows = 40;

localparam vec_t VecTab [NumRows] = '{
  // Entry 0, pages 0x10..0x1F, read only, upper data bits must be dropped
  '{OpCfgWr,    8'h00, 32'hFFF0_0010, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h01, 32'h0000_001F, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h02, 32'hFFC3_0000, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h03, 32'hFFFF_FFFB, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  // Entry 1, pages 0x20..0x2F, write only
  '{OpCfgWr,    8'h04, 32'h0000_0020, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h05, 32'h0000_002F, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h06, 32'h0000_1000, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h07, 32'h0000_0005, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  // Entry 2, pages 0x18..0x27, read and write, overlaps entries 0 and 1
  '{OpCfgWr,    8'h08, 32'h0000_0018, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h09, 32'h0000_0027, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h0A, 32'h0002_0000, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h0B, 32'h0000_0007, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  // Entry 3, pages 0x100..0x1FF, permitted but not yet valid
  '{OpCfgWr,    8'h0C, 32'h0000_0100, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h0D, 32'h0000_01FF, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h0E, 32'hFFFF_FF00, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgWr,    8'h0F, 32'h0000_0006, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  // Readback masked to 20, 22 and 3 bits
  '{OpCfgRd,    8'h00, 32'h0000_0010, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h01, 32'h0000_001F, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h02, 32'h0003_0000, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h03, 32'h0000_0003, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h0E, 32'h003F_FF00, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h0F, 32'h0000_0006, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  // Words past entry 3 are unmapped
  '{OpCfgWr,    8'h10, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h10, 32'h0000_0000, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'hFF, 32'h0000_0000, 32'h0000_0000, 1'b0, 34'h0_0000_0000},
  // Read hit in entry 0, same address misses for writes
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0001_5ABC, 1'b1, 34'h0_3000_5ABC},
  '{OpLookupWr, 8'h00, 32'h0000_0000, 32'h0001_5ABC, 1'b0, 34'h0_0000_0000},
  // Entry 1 wins writes over entry 2, reads fall to entry 2
  '{OpLookupWr, 8'h00, 32'h0000_0000, 32'h0002_4123, 1'b1, 34'h0_0100_4123},
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0002_4123, 1'b1, 34'h0_2000_C123},
  // Page 0x1A, entry 0 wins reads and entry 2 takes writes
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0001_A7FF, 1'b1, 34'h0_3000_A7FF},
  '{OpLookupWr, 8'h00, 32'h0000_0000, 32'h0001_A7FF, 1'b1, 34'h0_2000_27FF},
  // Range ends are inclusive
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0001_FFFF, 1'b1, 34'h0_3000_FFFF},
  '{OpLookupWr, 8'h00, 32'h0000_0000, 32'h0002_0000, 1'b1, 34'h0_0100_0000},
  // Page 0x2C lies only in write-only entry 1, so reads miss
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0002_C000, 1'b0, 34'h0_0000_0000},
  // Invalid entry and an address outside every range
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0015_0000, 1'b0, 34'h0_0000_0000},
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'hFFFF_F000, 1'b0, 34'h0_0000_0000},
  // Miss held while entry 3 becomes valid and readable
  '{OpHoldRd,   8'h0F, 32'h0000_0003, 32'h0015_0004, 1'b0, 34'h0_0000_0000},
  // New table seen by the next lookup, output upper bits in use
  '{OpLookupRd, 8'h00, 32'h0000_0000, 32'h0015_0004, 1'b1, 34'h3_FFF5_0004},
  '{OpLookupWr, 8'h00, 32'h0000_0000, 32'h0015_0004, 1'b0, 34'h0_0000_0000},
  '{OpCfgRd,    8'h0F, 32'h0000_0003, 32'h0000_0000, 1'b0, 34'h0_0000_0000}
};

`endif

// ==== tb/tb_tlb_l1.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tlb_l1;

  localparam int unsigned NumEntries   = 4;
  // Valid cycles with ready forced low in a held lookup
  localparam int unsigned HoldCycles   = 4;
  localparam int unsigned CyclesPerRow = 50;
  // Delay after the falling edge before outputs are sampled
  localparam int unsigned Settle       = 1;
  localparam logic [31:0] Seed         = 32'hbd01_cd1e;

  `include "tb_tlb_l1_vectors.svh"

  // Budget covers reset and the final idle cycles as one extra row
  localparam int unsigned MaxCycles = (NumRows + 1) * CyclesPerRow;

  logic                    clk;
  logic                    rst_n;
  logic                    cfg_we;
  tlb_cfg_pkg::cfg_addr_t  cfg_addr;
  tlb_cfg_pkg::cfg_data_t  cfg_wdata;
  tlb_cfg_pkg::cfg_data_t  cfg_rdata;
  tlb_xlat_pkg::inp_addr_t wr_req_addr;
  logic                    wr_req_valid;
  logic                    wr_req_ready;
  logic                    wr_res_hit;
  tlb_xlat_pkg::oup_addr_t wr_res_addr;
  logic                    wr_res_valid;
  logic                    wr_res_ready;
  tlb_xlat_pkg::inp_addr_t rd_req_addr;
  logic                    rd_req_valid;
  logic                    rd_req_ready;
  logic                    rd_res_hit;
  tlb_xlat_pkg::oup_addr_t rd_res_addr;
  logic                    rd_res_valid;
  logic                    rd_res_ready;

  int unsigned err_cnt   = 0;
  int unsigned chk_cnt   = 0;
  int unsigned cycle_cnt = 0;
  logic [31:0] lfsr_q;

  tb_clk_gen #(
    .PeriodNs  (20),
    .RstCycles (5)
  ) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tlb_l1_top #(
    .NumEntries (NumEntries)
  ) DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cfg_we_i       (cfg_we),
    .cfg_addr_i     (cfg_addr),
    .cfg_wdata_i    (cfg_wdata),
    .cfg_rdata_o    (cfg_rdata),
    .wr_req_addr_i  (wr_req_addr),
    .wr_req_valid_i (wr_req_valid),
    .wr_req_ready_o (wr_req_ready),
    .wr_res_hit_o   (wr_res_hit),
    .wr_res_addr_o  (wr_res_addr),
    .wr_res_valid_o (wr_res_valid),
    .wr_res_ready_i (wr_res_ready),
    .rd_req_addr_i  (rd_req_addr),
    .rd_req_valid_i (rd_req_valid),
    .rd_req_ready_o (rd_req_ready),
    .rd_res_hit_o   (rd_res_hit),
    .rd_res_addr_o  (rd_res_addr),
    .rd_res_valid_o (rd_res_valid),
    .rd_res_ready_i (rd_res_ready)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic take_random_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b = lfsr_q[0];
  endtask

  task automatic cfg_write(input tlb_cfg_pkg::cfg_addr_t a, input tlb_cfg_pkg::cfg_data_t d);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  // Combinational readback, sampled while the address is stable
  task automatic cfg_read_check(input int row, input tlb_cfg_pkg::cfg_addr_t a,
                                input tlb_cfg_pkg::cfg_data_t exp);
    @(negedge clk);
    cfg_addr = a;
    #Settle;
    chk_cnt++;
    if (cfg_rdata !== exp) begin
      err_cnt++;
      $display("** Error: cfg_rdata_o = 0x%0h, expected 0x%0h (row %0d, addr 0x%0h)",
               cfg_rdata, exp, row, a);
    end
  endtask

  // One lookup on either channel, every valid result cycle checked
  task automatic run_lookup(input int row, input vec_t v);
    logic                    is_wr;
    logic                    hold;
    logic                    req_done;
    logic                    res_done;
    logic                    full_exp;
    logic                    rdy;
    logic                    req_rdy;
    logic                    res_vld;
    logic                    res_hit;
    tlb_xlat_pkg::oup_addr_t res_addr;
    int unsigned             held;
    string                   ch;
    is_wr    = (v.op == OpLookupWr);
    hold     = (v.op == OpHoldRd);
    ch       = is_wr ? "wr" : "rd";
    req_done = 1'b0;
    res_done = 1'b0;
    full_exp = 1'b0;
    held     = 0;
    while (!res_done) begin
      @(negedge clk);
      if (hold && held < HoldCycles) begin
        rdy = 1'b0;
      end else begin
        take_random_bit(rdy);
      end
      // Request stays up until accepted
      if (is_wr) begin
        wr_req_valid = !req_done;
        wr_req_addr  = v.req_addr;
        wr_res_ready = rdy;
      end else begin
        rd_req_valid = !req_done;
        rd_req_addr  = v.req_addr;
        rd_res_ready = rdy;
      end
      // Table write in the second held cycle
      if (hold) begin
        cfg_we    = (held == 1);
        cfg_addr  = v.cfg_addr;
        cfg_wdata = v.cfg_data;
      end
      #Settle;
      req_rdy  = is_wr ? wr_req_ready : rd_req_ready;
      res_vld  = is_wr ? wr_res_valid : rd_res_valid;
      res_hit  = is_wr ? wr_res_hit   : rd_res_hit;
      res_addr = is_wr ? wr_res_addr  : rd_res_addr;
      // Empty register takes the request, a held result blocks it
      chk_cnt++;
      if (req_rdy !== !full_exp) begin
        err_cnt++;
        $display("** Error: %s_req_ready_o = 0x%0h, expected 0x%0h (row %0d)",
                 ch, req_rdy, !full_exp, row);
      end
      // Result shows in the request cycle and stays until taken
      chk_cnt++;
      if (res_vld !== 1'b1) begin
        err_cnt++;
        $display("** Error: %s_res_valid_o = 0x%0h, expected 0x1 (row %0d)",
                 ch, res_vld, row);
      end
      if (!req_done && req_rdy) begin
        req_done = 1'b1;
      end
      if (res_vld) begin
        chk_cnt++;
        if (res_hit !== v.exp_hit) begin
          err_cnt++;
          $display("** Error: %s_res_hit_o = 0x%0h, expected 0x%0h (row %0d)",
                   ch, res_hit, v.exp_hit, row);
        end
        chk_cnt++;
        if (res_addr !== v.exp_addr) begin
          err_cnt++;
          $display("** Error: %s_res_addr_o = 0x%0h, expected 0x%0h (row %0d)",
                   ch, res_addr, v.exp_addr, row);
        end
        // Untaken result is held from the next cycle on
        full_exp = !rdy;
        if (rdy) begin
          res_done = 1'b1;
        end else begin
          held++;
        end
      end
    end
    if (!req_done) begin
      err_cnt++;
      $display("Row %0d returned a %s result before its request was accepted", row, ch);
    end
    // Transfer happens on the edge just passed, channel goes idle
    @(negedge clk);
    cfg_we       = 1'b0;
    wr_req_valid = 1'b0;
    wr_res_ready = 1'b0;
    rd_req_valid = 1'b0;
    rd_res_ready = 1'b0;
  endtask

  // Ends a run whose handshakes stall
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MaxCycles) begin
      $display("Timeout after %0d cycles, a lookup result never completed", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin : stimulus
    vec_t v;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    wr_req_addr  = '0;
    wr_req_valid = 1'b0;
    wr_res_ready = 1'b0;
    rd_req_addr  = '0;
    rd_req_valid = 1'b0;
    rd_res_ready = 1'b0;
    lfsr_q       = Seed;
    wait (rst_n === 1'b1);
    // Both result registers empty after reset
    @(negedge clk);
    #Settle;
    chk_cnt++;
    if (wr_res_valid !== 1'b0) begin
      err_cnt++;
      $display("** Error: wr_res_valid_o = 0x%0h, expected 0x0 after reset", wr_res_valid);
    end
    chk_cnt++;
    if (rd_res_valid !== 1'b0) begin
      err_cnt++;
      $display("** Error: rd_res_valid_o = 0x%0h, expected 0x0 after reset", rd_res_valid);
    end
    for (int i = 0; i < NumRows; i++) begin
      v = VecTab[i];
      case (v.op)
        OpCfgWr: cfg_write(v.cfg_addr, v.cfg_data);
        OpCfgRd: cfg_read_check(i, v.cfg_addr, v.cfg_data);
        default: run_lookup(i, v);
      endcase
    end
    @(negedge clk);
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
common/tlb_xlat_pkg.sv
common/tlb_cfg_pkg.sv
tlb_l1/tlb_l1_ft_reg.sv
tlb_l1/tlb_l1_regs.sv
tlb_l1/tlb_l1_chan.sv
src/tlb_l1_top.sv
tb/tb_clk_gen.sv
tb/tb_tlb_l1.sv
